/* hdl/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath widths
`define XLEN      32
`define PC_W      16
`define REG_AW    5
`define ALU_SEL_W 4

// One forwarding unit per source register
`define N_SRC     2

// Major opcodes of the supported RV32I subset
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111

`endif

/* hdl/isa_pkg.sv */
`include "decode_consts.svh"

package isa_pkg;

  // Instruction word and register data
  typedef logic [`XLEN-1:0] instr_t;
  typedef logic [`XLEN-1:0] word_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Register file index, x0..x31
  typedef logic [`REG_AW-1:0] reg_addr_t;

endpackage

/* hdl/pipe_pkg.sv */
`include "decode_consts.svh"

package pipe_pkg;

  // Fetch address, narrower than the data word
  typedef logic [`PC_W-1:0] pc_t;

  // ALU operation select
  // {funct7[5], funct3}, zero outside the ALU classes
  typedef logic [`ALU_SEL_W-1:0] alu_sel_t;

endpackage

/* hdl/decode_ifs.sv */
`timescale 1ns/10ps

// Later-stage state seen by the forwarding units
interface fwd_src_if import isa_pkg::*; ();
  reg_addr_t idex_rd;
  logic      idex_reg_write;
  logic      idex_mem_read;
  word_t     ex_alures;

  reg_addr_t exmem_rd;
  logic      exmem_reg_write;
  logic      exmem_mem_read;
  word_t     exmem_alures;

  reg_addr_t memwb_rd;
  logic      memwb_reg_write;
  word_t     wb_res;

  modport src (
    output idex_rd, idex_reg_write, idex_mem_read, ex_alures,
    output exmem_rd, exmem_reg_write, exmem_mem_read, exmem_alures,
    output memwb_rd, memwb_reg_write, wb_res
  );

  modport sink (
    input idex_rd, idex_reg_write, idex_mem_read, ex_alures,
    input exmem_rd, exmem_reg_write, exmem_mem_read, exmem_alures,
    input memwb_rd, memwb_reg_write, wb_res
  );
endinterface

// One source operand, from address to forwarded value
interface operand_if import isa_pkg::*; ();
  reg_addr_t addr;
  word_t     raw;
  word_t     value;
  logic      wait_ex;
  logic      wait_mem;

  modport dec (output addr);
  modport fwd (input addr, raw, output value, wait_ex, wait_mem);
  modport user (input value, wait_ex, wait_mem);
endinterface

/* hdl/instr_decode.sv */
`timescale 1ns/10ps
`include "decode_consts.svh"

module instr_decode import isa_pkg::*, pipe_pkg::*; (
  input  instr_t    ins,
  input  logic      flush,
  operand_if.dec    ops [`N_SRC],
  output reg_addr_t rd,
  output funct3_t   funct3,
  output word_t     imm,
  output alu_sel_t  alu_sel,
  output logic      alu_src,
  output logic      mem_read,
  output logic      mem_write,
  output logic      reg_write,
  output logic      branch,
  output logic      jal,
  output logic      jalr,
  output logic      lui,
  output logic      use_rs1,
  output logic      use_rs2
);

  opcode_t opcode;
  logic    shift_right;

  assign opcode      = ins[6:0];
  assign funct3      = ins[14:12];
  assign ops[0].addr = ins[19:15];
  assign ops[1].addr = ins[24:20];
  // srli/srai share funct3, bit 30 picks arithmetic
  assign shift_right = (funct3 == 3'b101);

  // Store, branch and bubbles never write a register
  assign rd = reg_write ? ins[11:7] : '0;

  ////////////////////
  // Immediate generation
  always_comb begin
    case (opcode)
      `OP_ITYPE, `OP_LOAD, `OP_JALR:
        imm = {{20{ins[31]}}, ins[31:20]};
      `OP_STORE:
        imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      `OP_BRANCH:
        imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      `OP_JAL:
        imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      `OP_LUI:
        imm = {ins[31:12], 12'h000};
      default:
        imm = '0;
    endcase
  end

  ////////////////////
  // Control decode
  always_comb begin
    alu_sel   = '0;
    alu_src   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    jalr      = 1'b0;
    lui       = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    // Flushed slot decodes as a bubble
    if (!flush) begin
      case (opcode)
        `OP_RTYPE: begin
          alu_sel   = {ins[30], funct3};
          reg_write = 1'b1;
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
        end
        `OP_ITYPE: begin
          alu_sel   = {ins[30] & shift_right, funct3};
          alu_src   = 1'b1;
          reg_write = 1'b1;
          use_rs1   = 1'b1;
        end
        `OP_LOAD: begin
          alu_src   = 1'b1;
          mem_read  = 1'b1;
          reg_write = 1'b1;
          use_rs1   = 1'b1;
        end
        `OP_STORE: begin
          alu_src   = 1'b1;
          mem_write = 1'b1;
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
        end
        `OP_BRANCH: begin
          branch  = 1'b1;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
        `OP_JAL: begin
          jal       = 1'b1;
          reg_write = 1'b1;
        end
        `OP_JALR: begin
          jalr      = 1'b1;
          alu_src   = 1'b1;
          reg_write = 1'b1;
          use_rs1   = 1'b1;
        end
        `OP_LUI: begin
          lui       = 1'b1;
          alu_src   = 1'b1;
          reg_write = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* hdl/operand_fwd.sv */
`timescale 1ns/10ps

module operand_fwd (
  fwd_src_if.sink src,
  operand_if.fwd  op
);

  logic hit_ex;
  logic hit_mem;
  logic hit_wb;

  // A stage matches only when it writes a nonzero rd
  assign hit_ex  = src.idex_reg_write && (src.idex_rd != 5'd0) &&
                   (src.idex_rd == op.addr);
  assign hit_mem = src.exmem_reg_write && (src.exmem_rd != 5'd0) &&
                   (src.exmem_rd == op.addr);
  assign hit_wb  = src.memwb_reg_write && (src.memwb_rd != 5'd0) &&
                   (src.memwb_rd == op.addr);

  // Youngest producer wins
  always_comb begin
    if (hit_ex)
      op.value = src.ex_alures;
    else if (hit_mem)
      op.value = src.exmem_alures;
    else if (hit_wb)
      op.value = src.wb_res;
    else
      op.value = op.raw;
  end

  // Load data not yet available
  assign op.wait_ex  = hit_ex && src.idex_mem_read;
  assign op.wait_mem = hit_mem && src.exmem_mem_read && !hit_ex;

endmodule

/* hdl/hazard_branch.sv */
`timescale 1ns/10ps
`include "decode_consts.svh"

module hazard_branch import isa_pkg::*, pipe_pkg::*; (
  operand_if.user ops [`N_SRC],
  input  logic    use_rs1,
  input  logic    use_rs2,
  input  logic    branch,
  input  logic    jal,
  input  logic    jalr,
  input  funct3_t funct3,
  input  word_t   imm,
  input  pc_t     pc,
  output logic    hz,
  output logic    branch_taken,
  output pc_t     branoff
);

  word_t rs1_val;
  word_t rs2_val;
  word_t jalr_sum;
  logic  stall_ex;
  logic  stall_mem;
  logic  cond;

  assign rs1_val = ops[0].value;
  assign rs2_val = ops[1].value;

  ////////////////////
  // Stall decision
  assign stall_ex  = (use_rs1 && ops[0].wait_ex) || (use_rs2 && ops[1].wait_ex);
  // Compare in decode cannot wait one more stage for load data
  assign stall_mem = ((use_rs1 && ops[0].wait_mem) || (use_rs2 && ops[1].wait_mem)) &&
                     (branch || jalr);
  assign hz = stall_ex || stall_mem;

  ////////////////////
  // Branch condition
  always_comb begin
    case (funct3)
      3'b000:  cond = (rs1_val == rs2_val);
      3'b001:  cond = (rs1_val != rs2_val);
      3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  cond = (rs1_val < rs2_val);
      3'b111:  cond = (rs1_val >= rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = !hz && (jal || jalr || (branch && cond));

  ////////////////////
  // Target address
  assign jalr_sum = rs1_val + imm;

  always_comb begin
    if (jalr)
      branoff = {jalr_sum[`PC_W-1:1], 1'b0};
    else
      branoff = pc + imm[`PC_W-1:0];
  end

endmodule

/* hdl/id_ex_reg.sv */
`timescale 1ns/10ps

module id_ex_reg import isa_pkg::*, pipe_pkg::*; (
  input  logic      bus,
  input  logic      rst_n,
  input  logic      mem_hold,
  input  logic      hz,
  input  logic      branch_taken,
  input  alu_sel_t  alu_sel,
  input  logic      alu_src,
  input  logic      mem_read,
  input  logic      mem_write,
  input  logic      reg_write,
  input  logic      jal,
  input  logic      jalr,
  input  logic      lui,
  input  funct3_t   funct3,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  word_t     dout_rs1,
  input  word_t     dout_rs2,
  input  word_t     imm,
  input  pc_t       pc,
  output alu_sel_t  id_ex_alu_sel,
  output logic      id_ex_alu_src,
  output logic      id_ex_mem_read,
  output logic      id_ex_mem_write,
  output logic      id_ex_reg_write,
  output logic      id_ex_jal,
  output logic      id_ex_jalr,
  output logic      id_ex_lui,
  output funct3_t   id_ex_funct3,
  output reg_addr_t id_ex_rs1,
  output reg_addr_t id_ex_rs2,
  output reg_addr_t id_ex_rd,
  output word_t     id_ex_dout_rs1,
  output word_t     id_ex_dout_rs2,
  output word_t     id_ex_imm,
  output pc_t       id_ex_pc,
  output logic      flush
);

  ////////////////////
  // Controls and register addresses
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      id_ex_alu_sel   <= '0;
      id_ex_alu_src   <= 1'b0;
      id_ex_mem_read  <= 1'b0;
      id_ex_mem_write <= 1'b0;
      id_ex_reg_write <= 1'b0;
      id_ex_jal       <= 1'b0;
      id_ex_jalr      <= 1'b0;
      id_ex_lui       <= 1'b0;
      id_ex_funct3    <= '0;
      id_ex_rs1       <= '0;
      id_ex_rs2       <= '0;
      id_ex_rd        <= '0;
      flush           <= 1'b0;
    end else if (!mem_hold) begin
      // branch_taken is already low during a stall
      flush <= branch_taken;
      if (hz) begin
        id_ex_alu_sel   <= '0;
        id_ex_alu_src   <= 1'b0;
        id_ex_mem_read  <= 1'b0;
        id_ex_mem_write <= 1'b0;
        id_ex_reg_write <= 1'b0;
        id_ex_jal       <= 1'b0;
        id_ex_jalr      <= 1'b0;
        id_ex_lui       <= 1'b0;
        id_ex_funct3    <= '0;
        id_ex_rs1       <= '0;
        id_ex_rs2       <= '0;
        id_ex_rd        <= '0;
      end else begin
        id_ex_alu_sel   <= alu_sel;
        id_ex_alu_src   <= alu_src;
        id_ex_mem_read  <= mem_read;
        id_ex_mem_write <= mem_write;
        id_ex_reg_write <= reg_write;
        id_ex_jal       <= jal;
        id_ex_jalr      <= jalr;
        id_ex_lui       <= lui;
        id_ex_funct3    <= funct3;
        id_ex_rs1       <= rs1;
        id_ex_rs2       <= rs2;
        id_ex_rd        <= rd;
      end
    end
  end

  ////////////////////
  // Operand data, immediate and pc
  always_ff @(posedge bus) begin
    if (!mem_hold) begin
      // pc passes even through a bubble
      id_ex_pc <= pc;
      if (hz) begin
        id_ex_dout_rs1 <= '0;
        id_ex_dout_rs2 <= '0;
        id_ex_imm      <= '0;
      end else begin
        id_ex_dout_rs1 <= dout_rs1;
        id_ex_dout_rs2 <= dout_rs2;
        id_ex_imm      <= imm;
      end
    end
  end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/10ps
`include "decode_consts.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic      bus,
  input  logic      rst_n,
  input  logic      mem_hold,
  input  instr_t    ins,
  input  pc_t       if_id_pc,
  input  word_t     dout_rs1,
  input  word_t     dout_rs2,
  input  word_t     ex_alures,
  input  reg_addr_t ex_mem_rd,
  input  logic      ex_mem_reg_write,
  input  logic      ex_mem_mem_read,
  input  word_t     ex_mem_alures,
  input  reg_addr_t mem_wb_rd,
  input  logic      mem_wb_reg_write,
  input  word_t     wb_res,
  output reg_addr_t if_id_rs1,
  output reg_addr_t if_id_rs2,
  output logic      hz,
  output logic      branch_taken,
  output pc_t       branoff,
  output alu_sel_t  id_ex_alu_sel,
  output logic      id_ex_alu_src,
  output logic      id_ex_mem_read,
  output logic      id_ex_mem_write,
  output logic      id_ex_reg_write,
  output logic      id_ex_jal,
  output logic      id_ex_jalr,
  output logic      id_ex_lui,
  output funct3_t   id_ex_funct3,
  output reg_addr_t id_ex_rs1,
  output reg_addr_t id_ex_rs2,
  output reg_addr_t id_ex_rd,
  output word_t     id_ex_dout_rs1,
  output word_t     id_ex_dout_rs2,
  output word_t     id_ex_imm,
  output pc_t       id_ex_pc
);

  // Decoded fields of the instruction in ID
  reg_addr_t rd;
  funct3_t   funct3;
  word_t     imm;
  alu_sel_t  alu_sel;
  logic      alu_src;
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;
  logic      branch;
  logic      jal;
  logic      jalr;
  logic      lui;
  logic      use_rs1;
  logic      use_rs2;
  logic      flush;

  fwd_src_if fwd ();
  operand_if ops [`N_SRC] ();

  ////////////////////
  // Later-stage state for forwarding
  assign fwd.idex_rd         = id_ex_rd;
  assign fwd.idex_reg_write  = id_ex_reg_write;
  assign fwd.idex_mem_read   = id_ex_mem_read;
  assign fwd.ex_alures       = ex_alures;
  assign fwd.exmem_rd        = ex_mem_rd;
  assign fwd.exmem_reg_write = ex_mem_reg_write;
  assign fwd.exmem_mem_read  = ex_mem_mem_read;
  assign fwd.exmem_alures    = ex_mem_alures;
  assign fwd.memwb_rd        = mem_wb_rd;
  assign fwd.memwb_reg_write = mem_wb_reg_write;
  assign fwd.wb_res          = wb_res;

  // Register file read ports
  assign ops[0].raw = dout_rs1;
  assign ops[1].raw = dout_rs2;
  assign if_id_rs1  = ops[0].addr;
  assign if_id_rs2  = ops[1].addr;

  instr_decode u_instr_decode (
    .ins       (ins),
    .flush     (flush),
    .ops       (ops),
    .rd        (rd),
    .funct3    (funct3),
    .imm       (imm),
    .alu_sel   (alu_sel),
    .alu_src   (alu_src),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .reg_write (reg_write),
    .branch    (branch),
    .jal       (jal),
    .jalr      (jalr),
    .lui       (lui),
    .use_rs1   (use_rs1),
    .use_rs2   (use_rs2)
  );

  for (genvar i = 0; i < `N_SRC; i++) begin : g_fwd
    operand_fwd u_operand_fwd (
      .src (fwd),
      .op  (ops[i])
    );
  end

  hazard_branch u_hazard_branch (
    .ops          (ops),
    .use_rs1      (use_rs1),
    .use_rs2      (use_rs2),
    .branch       (branch),
    .jal          (jal),
    .jalr         (jalr),
    .funct3       (funct3),
    .imm          (imm),
    .pc           (if_id_pc),
    .hz           (hz),
    .branch_taken (branch_taken),
    .branoff      (branoff)
  );

  id_ex_reg u_id_ex_reg (
    .bus             (bus),
    .rst_n           (rst_n),
    .mem_hold        (mem_hold),
    .hz              (hz),
    .branch_taken    (branch_taken),
    .alu_sel         (alu_sel),
    .alu_src         (alu_src),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .reg_write       (reg_write),
    .jal             (jal),
    .jalr            (jalr),
    .lui             (lui),
    .funct3          (funct3),
    .rs1             (if_id_rs1),
    .rs2             (if_id_rs2),
    .rd              (rd),
    .dout_rs1        (dout_rs1),
    .dout_rs2        (dout_rs2),
    .imm             (imm),
    .pc              (if_id_pc),
    .id_ex_alu_sel   (id_ex_alu_sel),
    .id_ex_alu_src   (id_ex_alu_src),
    .id_ex_mem_read  (id_ex_mem_read),
    .id_ex_mem_write (id_ex_mem_write),
    .id_ex_reg_write (id_ex_reg_write),
    .id_ex_jal       (id_ex_jal),
    .id_ex_jalr      (id_ex_jalr),
    .id_ex_lui       (id_ex_lui),
    .id_ex_funct3    (id_ex_funct3),
    .id_ex_rs1       (id_ex_rs1),
    .id_ex_rs2       (id_ex_rs2),
    .id_ex_rd        (id_ex_rd),
    .id_ex_dout_rs1  (id_ex_dout_rs1),
    .id_ex_dout_rs2  (id_ex_dout_rs2),
    .id_ex_imm       (id_ex_imm),
    .id_ex_pc        (id_ex_pc),
    .flush           (flush)
  );

endmodule

/* tb/decode_checker.sv */
`timescale 1ns/10ps

module decode_checker import isa_pkg::*, pipe_pkg::*; (
  input logic      bus,
  input logic      rst_n,
  input logic      mem_hold,
  input logic      hz,
  input logic      branch_taken,
  input logic      flush,
  input alu_sel_t  id_ex_alu_sel,
  input logic      id_ex_alu_src,
  input logic      id_ex_mem_read,
  input logic      id_ex_mem_write,
  input logic      id_ex_reg_write,
  input logic      id_ex_jal,
  input logic      id_ex_jalr,
  input logic      id_ex_lui,
  input funct3_t   id_ex_funct3,
  input reg_addr_t id_ex_rs1,
  input reg_addr_t id_ex_rs2,
  input reg_addr_t id_ex_rd,
  input word_t     id_ex_dout_rs1,
  input word_t     id_ex_dout_rs2,
  input word_t     id_ex_imm,
  input pc_t       id_ex_pc
);

  logic [10:0]  ctrl;
  logic [141:0] idex_all;

  assign ctrl = {id_ex_alu_sel, id_ex_alu_src, id_ex_mem_read, id_ex_mem_write,
                 id_ex_reg_write, id_ex_jal, id_ex_jalr, id_ex_lui};

  // Whole ID_EX register plus the pending flush
  assign idex_all = {ctrl, id_ex_funct3, id_ex_rs1, id_ex_rs2, id_ex_rd,
                     id_ex_dout_rs1, id_ex_dout_rs2, id_ex_imm, id_ex_pc, flush};

  ////////////////////
  // Properties
  a_no_take_on_stall: assert property (@(posedge bus) disable iff (!rst_n)
    (hz || flush) |-> !branch_taken)
    else $error("branch_taken raised during a stall or in a flushed slot");

  a_hold_keeps_state: assert property (@(posedge bus) disable iff (!rst_n)
    mem_hold |=> $stable(idex_all))
    else $error("ID_EX state changed under mem_hold");

  a_reset_clears_ctrl: assert property (@(posedge bus)
    !rst_n |=> (ctrl == '0))
    else $error("ID_EX controls not cleared by reset");

endmodule

bind decode_stage decode_checker u_decode_checker (.*);

/* tb/tb_decode_stage.sv */
`timescale 1ns/10ps
`include "decode_consts.svh"

module tb_decode_stage import isa_pkg::*, pipe_pkg::*; ();

  localparam int SEED           = 55675;
  localparam int NUM_INSTR      = 1500;
  localparam int TIMEOUT_CYCLES = 2000;

  // Contents of the ID_EX register
  typedef struct packed {
    alu_sel_t  alu_sel;
    logic      alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      jal;
    logic      jalr;
    logic      lui;
    funct3_t   funct3;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     dout_rs1;
    word_t     dout_rs2;
    word_t     imm;
    pc_t       pc;
  } idex_t;

  // Expected decode of the instruction in ID
  typedef struct packed {
    idex_t fields;
    logic  hz;
    logic  taken;
    pc_t   branoff;
  } dec_exp_t;

  logic      bus;
  logic      rst_n;
  logic      mem_hold;
  instr_t    ins;
  pc_t       if_id_pc;
  word_t     dout_rs1;
  word_t     dout_rs2;
  word_t     ex_alures;
  reg_addr_t ex_mem_rd;
  logic      ex_mem_reg_write;
  logic      ex_mem_mem_read;
  word_t     ex_mem_alures;
  reg_addr_t mem_wb_rd;
  logic      mem_wb_reg_write;
  word_t     wb_res;
  reg_addr_t if_id_rs1;
  reg_addr_t if_id_rs2;
  logic      hz;
  logic      branch_taken;
  pc_t       branoff;
  alu_sel_t  id_ex_alu_sel;
  logic      id_ex_alu_src;
  logic      id_ex_mem_read;
  logic      id_ex_mem_write;
  logic      id_ex_reg_write;
  logic      id_ex_jal;
  logic      id_ex_jalr;
  logic      id_ex_lui;
  funct3_t   id_ex_funct3;
  reg_addr_t id_ex_rs1;
  reg_addr_t id_ex_rs2;
  reg_addr_t id_ex_rd;
  word_t     id_ex_dout_rs1;
  word_t     id_ex_dout_rs2;
  word_t     id_ex_imm;
  pc_t       id_ex_pc;

  // Reference copy of ID_EX and of the flush flag
  idex_t model       = '0;
  logic  model_flush = 1'b0;
  int    compared    = 0;
  int    cycles      = 0;

  decode_stage u_decode_stage (.*);

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  ////////////////////
  // Failure reporting
  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped on failure");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_alu(input string name, input alu_sel_t got, input alu_sel_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_funct3(input string name, input funct3_t got, input funct3_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  ////////////////////
  // Reference model
  // Youngest matching stage supplies the operand
  // x0 never matches
  function automatic word_t forward(input reg_addr_t a, input word_t raw,
                                    output logic w_ex, output logic w_mem);
    logic m_ex;
    logic m_mem;
    logic m_wb;
    m_ex  = model.reg_write && (a != '0) && (model.rd == a);
    m_mem = ex_mem_reg_write && (a != '0) && (ex_mem_rd == a);
    m_wb  = mem_wb_reg_write && (a != '0) && (mem_wb_rd == a);
    w_ex  = m_ex && model.mem_read;
    w_mem = m_mem && ex_mem_mem_read && !m_ex;
    if (m_ex)
      return ex_alures;
    if (m_mem)
      return ex_mem_alures;
    if (m_wb)
      return wb_res;
    return raw;
  endfunction

  function automatic dec_exp_t decode_ref(input instr_t i, input pc_t pc,
                                          input word_t raw1, input word_t raw2,
                                          input logic fl);
    dec_exp_t e;
    opcode_t  opc;
    word_t    v1;
    word_t    v2;
    word_t    sum;
    logic     wex1;
    logic     wex2;
    logic     wmem1;
    logic     wmem2;
    logic     use1;
    logic     use2;
    logic     br;
    logic     cond;
    opc  = i[6:0];
    e    = '0;
    use1 = 1'b0;
    use2 = 1'b0;
    br   = 1'b0;
    e.fields.funct3   = i[14:12];
    e.fields.rs1      = i[19:15];
    e.fields.rs2      = i[24:20];
    e.fields.dout_rs1 = raw1;
    e.fields.dout_rs2 = raw2;
    e.fields.pc       = pc;
    case (opc)
      `OP_ITYPE, `OP_LOAD, `OP_JALR: e.fields.imm = {{20{i[31]}}, i[31:20]};
      `OP_STORE:  e.fields.imm = {{20{i[31]}}, i[31:25], i[11:7]};
      `OP_BRANCH: e.fields.imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      `OP_JAL:    e.fields.imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      `OP_LUI:    e.fields.imm = {i[31:12], 12'h000};
      default:    e.fields.imm = '0;
    endcase
    // A flushed slot keeps its fields but loses every control
    if (!fl) begin
      case (opc)
        `OP_RTYPE: begin
          e.fields.alu_sel   = {i[30], i[14:12]};
          e.fields.reg_write = 1'b1;
          use1 = 1'b1;
          use2 = 1'b1;
        end
        `OP_ITYPE: begin
          e.fields.alu_sel   = {i[30] && (i[14:12] == 3'b101), i[14:12]};
          e.fields.alu_src   = 1'b1;
          e.fields.reg_write = 1'b1;
          use1 = 1'b1;
        end
        `OP_LOAD: begin
          e.fields.alu_src   = 1'b1;
          e.fields.mem_read  = 1'b1;
          e.fields.reg_write = 1'b1;
          use1 = 1'b1;
        end
        `OP_STORE: begin
          e.fields.alu_src   = 1'b1;
          e.fields.mem_write = 1'b1;
          use1 = 1'b1;
          use2 = 1'b1;
        end
        `OP_BRANCH: begin
          br   = 1'b1;
          use1 = 1'b1;
          use2 = 1'b1;
        end
        `OP_JAL: begin
          e.fields.jal       = 1'b1;
          e.fields.reg_write = 1'b1;
        end
        `OP_JALR: begin
          e.fields.jalr      = 1'b1;
          e.fields.alu_src   = 1'b1;
          e.fields.reg_write = 1'b1;
          use1 = 1'b1;
        end
        `OP_LUI: begin
          e.fields.lui       = 1'b1;
          e.fields.alu_src   = 1'b1;
          e.fields.reg_write = 1'b1;
        end
        default: begin
        end
      endcase
    end
    if (e.fields.reg_write)
      e.fields.rd = i[11:7];

    v1   = forward(e.fields.rs1, raw1, wex1, wmem1);
    v2   = forward(e.fields.rs2, raw2, wex2, wmem2);
    e.hz = (use1 && wex1) || (use2 && wex2) ||
           (((use1 && wmem1) || (use2 && wmem2)) && (br || e.fields.jalr));

    case (e.fields.funct3)
      3'b000:  cond = (v1 == v2);
      3'b001:  cond = (v1 != v2);
      3'b100:  cond = ($signed(v1) < $signed(v2));
      3'b101:  cond = ($signed(v1) >= $signed(v2));
      3'b110:  cond = (v1 < v2);
      3'b111:  cond = (v1 >= v2);
      default: cond = 1'b0;
    endcase
    e.taken = !e.hz && (e.fields.jal || e.fields.jalr || (br && cond));

    sum = v1 + e.fields.imm;
    if (e.fields.jalr)
      e.branoff = {sum[`PC_W-1:1], 1'b0};
    else
      e.branoff = pc + e.fields.imm[`PC_W-1:0];
    return e;
  endfunction

  // What the register holds after the coming rising edge
  task automatic advance_model(input dec_exp_t e);
    idex_t kept;
    if (!mem_hold) begin
      model_flush = e.taken;
      if (e.hz) begin
        model    = '0;
        model.pc = e.fields.pc;
      end else begin
        model = e.fields;
      end
    end
    if (!rst_n) begin
      // Data path has no reset
      kept           = model;
      model          = '0;
      model.dout_rs1 = kept.dout_rs1;
      model.dout_rs2 = kept.dout_rs2;
      model.imm      = kept.imm;
      model.pc       = kept.pc;
      model_flush    = 1'b0;
    end
  endtask

  ////////////////////
  // Compare on the falling edge, where all outputs are settled
  initial begin : compare
    dec_exp_t e;
    logic     started;
    started = 1'b0;
    @(posedge bus);
    forever begin
      @(negedge bus);
      e = decode_ref(ins, if_id_pc, dout_rs1, dout_rs2, model_flush);
      if (started) begin
        check_addr("if_id_rs1", if_id_rs1, e.fields.rs1);
        check_addr("if_id_rs2", if_id_rs2, e.fields.rs2);
        check_bit("hz", hz, e.hz);
        check_bit("branch_taken", branch_taken, e.taken);
        check_pc("branoff", branoff, e.branoff);
        check_alu("id_ex_alu_sel", id_ex_alu_sel, model.alu_sel);
        check_bit("id_ex_alu_src", id_ex_alu_src, model.alu_src);
        check_bit("id_ex_mem_read", id_ex_mem_read, model.mem_read);
        check_bit("id_ex_mem_write", id_ex_mem_write, model.mem_write);
        check_bit("id_ex_reg_write", id_ex_reg_write, model.reg_write);
        check_bit("id_ex_jal", id_ex_jal, model.jal);
        check_bit("id_ex_jalr", id_ex_jalr, model.jalr);
        check_bit("id_ex_lui", id_ex_lui, model.lui);
        check_funct3("id_ex_funct3", id_ex_funct3, model.funct3);
        check_addr("id_ex_rs1", id_ex_rs1, model.rs1);
        check_addr("id_ex_rs2", id_ex_rs2, model.rs2);
        check_addr("id_ex_rd", id_ex_rd, model.rd);
        check_word("id_ex_dout_rs1", id_ex_dout_rs1, model.dout_rs1);
        check_word("id_ex_dout_rs2", id_ex_dout_rs2, model.dout_rs2);
        check_word("id_ex_imm", id_ex_imm, model.imm);
        check_pc("id_ex_pc", id_ex_pc, model.pc);
        compared++;
      end
      advance_model(e);
      started = 1'b1;
    end
  end

  ////////////////////
  // Stimulus
  // Small register indices come up often so that forwarding matches happen
  function automatic reg_addr_t random_reg();
    if ($urandom_range(0, 3) != 0)
      return reg_addr_t'($urandom_range(0, 3));
    return reg_addr_t'($urandom);
  endfunction

  function automatic word_t random_word();
    case ($urandom_range(0, 3))
      0:       return '0;
      1:       return '1;
      2:       return word_t'($urandom_range(0, 3));
      default: return word_t'($urandom);
    endcase
  endfunction

  function automatic instr_t random_instr();
    instr_t  i;
    funct3_t f3;
    i        = instr_t'($urandom);
    i[11:7]  = random_reg();
    i[19:15] = random_reg();
    i[24:20] = random_reg();
    case ($urandom_range(0, 7))
      0: begin
        i[6:0]   = `OP_RTYPE;
        i[31]    = 1'b0;
        i[29:25] = 5'b00000;
      end
      1: i[6:0] = `OP_ITYPE;
      2: i[6:0] = `OP_LOAD;
      3: i[6:0] = `OP_STORE;
      4: begin
        // Only the six defined conditions
        f3 = funct3_t'($urandom_range(0, 5));
        if (f3 >= 3'd2)
          f3 = f3 + 3'd2;
        i[6:0]   = `OP_BRANCH;
        i[14:12] = f3;
      end
      5: i[6:0] = `OP_JAL;
      6: begin
        i[6:0]   = `OP_JALR;
        i[14:12] = 3'b000;
      end
      default: i[6:0] = `OP_LUI;
    endcase
    return i;
  endfunction

  task automatic drive_cycle();
    ins              <= random_instr();
    if_id_pc         <= pc_t'($urandom);
    dout_rs1         <= random_word();
    dout_rs2         <= random_word();
    ex_alures        <= random_word();
    ex_mem_rd        <= random_reg();
    ex_mem_reg_write <= ($urandom_range(0, 3) != 0);
    ex_mem_mem_read  <= ($urandom_range(0, 2) == 0);
    ex_mem_alures    <= random_word();
    mem_wb_rd        <= random_reg();
    mem_wb_reg_write <= ($urandom_range(0, 3) != 0);
    wb_res           <= random_word();
    mem_hold         <= ($urandom_range(0, 9) == 0);
  endtask

  initial begin : stimulus
    void'($urandom(SEED));
    rst_n            = 1'b0;
    mem_hold         = 1'b0;
    ins              = '0;
    if_id_pc         = '0;
    dout_rs1         = '0;
    dout_rs2         = '0;
    ex_alures        = '0;
    ex_mem_rd        = '0;
    ex_mem_reg_write = 1'b0;
    ex_mem_mem_read  = 1'b0;
    ex_mem_alures    = '0;
    mem_wb_rd        = '0;
    mem_wb_reg_write = 1'b0;
    wb_res           = '0;
    repeat (2) @(posedge bus);
    rst_n <= 1'b1;
    for (int n = 0; n < NUM_INSTR; n++) begin
      @(posedge bus);
      drive_cycle();
    end
    repeat (3) @(posedge bus);
    if (compared >= NUM_INSTR) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Only %0d cycles were compared", compared);
      stop_with_failure();
    end
  end

  // Run length bound
  initial begin : watchdog
    forever begin
      @(posedge bus);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        stop_with_failure();
      end
    end
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/decode_ifs.sv
hdl/instr_decode.sv
hdl/operand_fwd.sv
hdl/hazard_branch.sv
hdl/id_ex_reg.sv
hdl/decode_stage.sv
tb/decode_checker.sv
tb/tb_decode_stage.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_decode_stage -f tb.f
	./obj_dir/Vtb_decode_stage

clean:
	rm -rf obj_dir
